// ==== compile.f ====
source/lab_pkg.sv
source/tick_timer.sv
source/tick_counters.sv
source/seg_display.sv
source/alu4.sv
source/barrel_shifter.sv
source/code_converter.sv
source/lab_top.sv
verification/lab_checker.sv
verification/lab_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the lab bench with Verilator and runs it from the project root
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module lab_tb \
	-f compile.f

./obj_dir/Vlab_tb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
exit 0

// ==== source/alu4.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu4 (
	input  lab_pkg::alu_op_t op,
	input  lab_pkg::nibble_t a,
	input  lab_pkg::nibble_t b,
	output lab_pkg::nibble_t res,
	output logic             zero,
	output logic             carry,
	output logic             overflow
);

	import lab_pkg::*;

	logic [4:0] sum;
	logic [4:0] diff;
	logic       add_ovf;
	logic       sub_ovf;

	// bit 4 of diff is set exactly when a is below b unsigned
	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	// same-sign operands giving an opposite-sign sum
	assign add_ovf = (a[3] == b[3]) && (sum[3] != a[3]);
	assign sub_ovf = (a[3] != b[3]) && (diff[3] != a[3]);

	always_comb begin
		res      = '0;
		carry    = 1'b0;
		overflow = 1'b0;
		case (op)
			OP_ADD: begin
				res      = sum[3:0];
				carry    = sum[4];
				overflow = add_ovf;
			end
			OP_SUB: begin
				res      = diff[3:0];
				carry    = diff[4];
				overflow = sub_ovf;
			end
			OP_NOT:  res = ~a;
			OP_AND:  res = a & b;
			OP_OR:   res = a | b;
			OP_XOR:  res = a ^ b;
			OP_LT:   res = {3'b000, $signed(a) < $signed(b)};
			OP_EQ:   res = {3'b000, a == b};
			default: res = '0;
		endcase
	end

	assign zero = (res == '0);

endmodule

`default_nettype wire

// ==== source/barrel_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter (
	input  lab_pkg::word_t  data,
	input  lab_pkg::shamt_t shamt,
	input  logic            shift_left,
	input  logic            arith,
	output lab_pkg::word_t  q
);

	import lab_pkg::*;

	logic  fill;
	word_t stage [6];

	// right shifts copy the sign in only when arithmetic
	assign fill = arith & data[31];

	assign stage[0] = data;

	// stage i shifts by 16 >> i under control of shamt[4-i]
	for (genvar i = 0; i < 5; i++) begin : g_stage
		localparam int SH = 16 >> i;

		word_t shifted;

		assign shifted = shift_left ?
			{stage[i][31-SH:0], {SH{1'b0}}} :
			{{SH{fill}}, stage[i][31:SH]};

		assign stage[i+1] = shamt[4-i] ? shifted : stage[i];
	end

	assign q = stage[5];

endmodule

`default_nettype wire

// ==== source/code_converter.sv ====
`timescale 1ns/1ps
`default_nettype none

module code_converter (
	input  logic [7:0] mux_in,
	input  logic [1:0] mux_sel,
	input  logic [2:0] dec_in,
	input  logic       dec_en,
	input  logic [7:0] enc_in,
	input  logic       enc_en,
	output logic [1:0] mux_out,
	output logic [7:0] dec_out,
	output logic [2:0] enc_out,
	output logic       enc_valid
);

	// ~~~~~~~~~~~~~~~~~~~~
	// 4 to 1 mux
	// ~~~~~~~~~~~~~~~~~~~~

	assign mux_out = mux_in[{mux_sel, 1'b0} +: 2];

	// ~~~~~~~~~~~~~~~~~~~~
	// 3 to 8 decoder
	// ~~~~~~~~~~~~~~~~~~~~

	assign dec_out = dec_en ? (8'b0000_0001 << dec_in) : 8'b0000_0000;

	// ~~~~~~~~~~~~~~~~~~~~
	// 8 to 3 priority encoder
	// ~~~~~~~~~~~~~~~~~~~~

	logic [2:0] top_idx;

	// the scan runs upward so the highest set bit is the one that sticks
	always_comb begin
		top_idx = 3'd0;
		for (int i = 0; i < 8; i++) begin
			if (enc_in[i]) begin
				top_idx = 3'(i);
			end
		end
	end

	assign enc_valid = enc_en & (|enc_in);
	assign enc_out   = enc_valid ? top_idx : 3'd0;

endmodule

`default_nettype wire

// ==== source/lab_pkg.sv ====
`default_nettype none

package lab_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// timing and limits
	// ~~~~~~~~~~~~~~~~~~~~

	// tick period in clock cycles, short so simulation stays quick
	localparam int unsigned TICK_DIV = 10;
	localparam int unsigned TICK_W = 8;
	localparam int unsigned INC_MAX = 99;
	localparam int unsigned SEG_DIGITS = 8;

	// ~~~~~~~~~~~~~~~~~~~~
	// data types
	// ~~~~~~~~~~~~~~~~~~~~

	typedef logic [3:0] nibble_t;
	typedef logic [2:0] alu_op_t;
	typedef logic [31:0] word_t;
	typedef logic [4:0] shamt_t;
	typedef logic [7:0] inc_count_t;
	typedef logic [2:0] dec_count_t;

	// active low, bit 0 is segment a up to bit 6 for g, bit 7 is the dot
	typedef logic [7:0] seg_t;

	localparam seg_t SEG_BLANK = 8'hFF;

	// alu function select
	localparam alu_op_t OP_ADD = 3'd0;
	localparam alu_op_t OP_SUB = 3'd1;
	localparam alu_op_t OP_NOT = 3'd2;
	localparam alu_op_t OP_AND = 3'd3;
	localparam alu_op_t OP_OR  = 3'd4;
	localparam alu_op_t OP_XOR = 3'd5;
	localparam alu_op_t OP_LT  = 3'd6;
	localparam alu_op_t OP_EQ  = 3'd7;

endpackage

`default_nettype wire

// ==== source/lab_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lab_top (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                counter_en,
	input  lab_pkg::alu_op_t    alu_op,
	input  lab_pkg::nibble_t    alu_a,
	input  lab_pkg::nibble_t    alu_b,
	input  lab_pkg::word_t      sft_data,
	input  lab_pkg::shamt_t     sft_shamt,
	input  logic                sft_shift_left,
	input  logic                sft_arith,
	input  logic [7:0]          mux_in,
	input  logic [1:0]          mux_sel,
	input  logic [2:0]          dec_in,
	input  logic                dec_en,
	input  logic [7:0]          enc_in,
	input  logic                enc_en,
	output lab_pkg::inc_count_t inc_count,
	output lab_pkg::dec_count_t dec_count,
	output lab_pkg::seg_t       seg0,
	output lab_pkg::seg_t       seg1,
	output lab_pkg::seg_t       seg2,
	output lab_pkg::seg_t       seg3,
	output lab_pkg::seg_t       seg4,
	output lab_pkg::seg_t       seg5,
	output lab_pkg::seg_t       seg6,
	output lab_pkg::seg_t       seg7,
	output lab_pkg::nibble_t    alu_res,
	output logic                alu_zero,
	output logic                alu_carry,
	output logic                alu_overflow,
	output lab_pkg::word_t      sft_q,
	output logic [1:0]          mux_out,
	output logic [7:0]          dec_out,
	output logic [2:0]          enc_out,
	output logic                enc_valid
);

	logic tick;

	// ~~~~~~~~~~~~~~~~~~~~
	// counting and display
	// ~~~~~~~~~~~~~~~~~~~~

	tick_timer u_tick_timer (
		.clk    (clk),
		.arst_n (arst_n),
		.tick   (tick)
	);

	tick_counters u_tick_counters (
		.clk        (clk),
		.arst_n     (arst_n),
		.tick       (tick),
		.counter_en (counter_en),
		.inc_count  (inc_count),
		.dec_count  (dec_count)
	);

	seg_display u_seg_display (
		.clk       (clk),
		.arst_n    (arst_n),
		.inc_count (inc_count),
		.dec_count (dec_count),
		.seg0      (seg0),
		.seg1      (seg1),
		.seg2      (seg2),
		.seg3      (seg3),
		.seg4      (seg4),
		.seg5      (seg5),
		.seg6      (seg6),
		.seg7      (seg7)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// combinational blocks
	// ~~~~~~~~~~~~~~~~~~~~

	alu4 u_alu4 (
		.op       (alu_op),
		.a        (alu_a),
		.b        (alu_b),
		.res      (alu_res),
		.zero     (alu_zero),
		.carry    (alu_carry),
		.overflow (alu_overflow)
	);

	barrel_shifter u_barrel_shifter (
		.data       (sft_data),
		.shamt      (sft_shamt),
		.shift_left (sft_shift_left),
		.arith      (sft_arith),
		.q          (sft_q)
	);

	code_converter u_code_converter (
		.mux_in    (mux_in),
		.mux_sel   (mux_sel),
		.dec_in    (dec_in),
		.dec_en    (dec_en),
		.enc_in    (enc_in),
		.enc_en    (enc_en),
		.mux_out   (mux_out),
		.dec_out   (dec_out),
		.enc_out   (enc_out),
		.enc_valid (enc_valid)
	);

endmodule

`default_nettype wire

// ==== source/seg_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg_display (
	input  logic                clk,
	input  logic                arst_n,
	input  lab_pkg::inc_count_t inc_count,
	input  lab_pkg::dec_count_t dec_count,
	output lab_pkg::seg_t       seg0,
	output lab_pkg::seg_t       seg1,
	output lab_pkg::seg_t       seg2,
	output lab_pkg::seg_t       seg3,
	output lab_pkg::seg_t       seg4,
	output lab_pkg::seg_t       seg5,
	output lab_pkg::seg_t       seg6,
	output lab_pkg::seg_t       seg7
);

	import lab_pkg::*;

	logic [3:0] ones;
	logic [3:0] tens;
	seg_t       seg_d [SEG_DIGITS];
	seg_t       seg_q [SEG_DIGITS];

	// anything above 9 shows as a dark digit
	function automatic seg_t digit_to_seg(input logic [3:0] digit);
		case (digit)
			4'd0:    return 8'hC0;
			4'd1:    return 8'hF9;
			4'd2:    return 8'hA4;
			4'd3:    return 8'hB0;
			4'd4:    return 8'h99;
			4'd5:    return 8'h92;
			4'd6:    return 8'h82;
			4'd7:    return 8'hF8;
			4'd8:    return 8'h80;
			4'd9:    return 8'h90;
			default: return SEG_BLANK;
		endcase
	endfunction

	assign ones = 4'(inc_count % 8'd10);
	assign tens = 4'(inc_count / 8'd10);

	always_comb begin
		for (int i = 0; i < SEG_DIGITS; i++) begin
			seg_d[i] = SEG_BLANK;
		end
		seg_d[0] = digit_to_seg(ones);
		seg_d[1] = digit_to_seg(tens);
		seg_d[2] = digit_to_seg({1'b0, dec_count});
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < SEG_DIGITS; i++) begin
				seg_q[i] <= SEG_BLANK;
			end
		end else begin
			seg_q <= seg_d;
		end
	end

	assign seg0 = seg_q[0];
	assign seg1 = seg_q[1];
	assign seg2 = seg_q[2];
	assign seg3 = seg_q[3];
	assign seg4 = seg_q[4];
	assign seg5 = seg_q[5];
	assign seg6 = seg_q[6];
	assign seg7 = seg_q[7];

endmodule

`default_nettype wire

// ==== source/tick_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module tick_counters (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                tick,
	input  logic                counter_en,
	output lab_pkg::inc_count_t inc_count,
	output lab_pkg::dec_count_t dec_count
);

	import lab_pkg::*;

	logic step;

	assign step = tick & counter_en;

	// ~~~~~~~~~~~~~~~~~~~~
	// up counter, 0 to 99
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			inc_count <= '0;
		end else if (step) begin
			if (inc_count == inc_count_t'(INC_MAX)) begin
				inc_count <= '0;
			end else begin
				inc_count <= inc_count + 1'b1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// down counter, 3 bits
	// ~~~~~~~~~~~~~~~~~~~~

	// wraps from 0 to 7 by plain underflow
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_count <= '0;
		end else if (step) begin
			dec_count <= dec_count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/tick_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tick_timer (
	input  logic clk,
	input  logic arst_n,
	output logic tick
);

	import lab_pkg::*;

	localparam logic [TICK_W-1:0] LAST = TICK_W'(TICK_DIV - 1);

	logic [TICK_W-1:0] div_cnt;

	// the pulse lands on the clock after the counter sits on its last value,
	// so the first tick appears TICK_DIV cycles out of reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end else if (div_cnt == LAST) begin
			div_cnt <= '0;
			tick    <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			tick    <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verification/lab_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module lab_checker (
	input logic                clk,
	input logic                arst_n,
	input logic                tick,
	input lab_pkg::inc_count_t inc_count,
	input lab_pkg::dec_count_t dec_count
);

	import lab_pkg::*;

	int fail_count = 0;

	// the up count never leaves its decimal range
	a_inc_range: assert property (@(posedge clk) disable iff (!arst_n)
		inc_count <= inc_count_t'(INC_MAX))
		else begin
			$error("inc_count went above its limit");
			fail_count++;
		end

	// counts move only on the edge that follows a tick
	a_step_on_tick: assert property (@(posedge clk) disable iff (!arst_n)
		($changed(inc_count) || $changed(dec_count)) |-> $past(tick))
		else begin
			$error("a count changed without a tick in the cycle before");
			fail_count++;
		end

	// tick is a single-cycle pulse
	a_tick_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		tick |=> !tick)
		else begin
			$error("tick stayed high for two cycles");
			fail_count++;
		end

endmodule

bind tick_counters lab_checker u_lab_checker (
	.clk       (clk),
	.arst_n    (arst_n),
	.tick      (tick),
	.inc_count (inc_count),
	.dec_count (dec_count)
);

`default_nettype wire

// ==== verification/lab_stim.txt ====
# A op a b res zero carry overflow (all hex)
# S data shamt left arith q
# C mux_in mux_sel dec_in dec_en enc_in enc_en mux_out dec_out enc_out enc_valid
A 0 3 4 7 0 0 0
A 0 7 1 8 0 0 1
A 0 8 8 0 1 1 1
A 0 f 1 0 1 1 0
A 1 5 3 2 0 0 0
A 1 3 5 e 0 1 0
A 1 8 1 7 0 0 1
A 1 7 f 8 0 1 1
A 1 6 6 0 1 0 0
A 2 a 0 5 0 0 0
A 3 c a 8 0 0 0
A 4 c 3 f 0 0 0
A 5 9 9 0 1 0 0
A 6 8 7 1 0 0 0
A 6 7 8 0 1 0 0
A 6 e f 1 0 0 0
A 7 a a 1 0 0 0
A 7 a b 0 1 0 0
S 00000001 04 1 0 00000010
S 80000000 1f 0 1 ffffffff
S 80000000 1f 0 0 00000001
S 12345678 08 0 1 00123456
S f0000000 04 0 1 ff000000
S 0000ffff 10 1 0 ffff0000
S 80000001 01 1 1 00000002
S a5a5a5a5 03 0 1 f4b4b4b4
C e4 0 0 1 01 1 0 01 0 1
C e4 1 3 1 0a 1 1 08 3 1
C e4 3 5 0 ff 1 3 00 7 1
C 1b 0 2 1 00 1 3 04 0 0
C 1b 3 6 1 3c 0 0 40 0 0
C 1b 1 4 1 7f 1 2 10 6 1

// ==== verification/lab_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lab_tb;

	import lab_pkg::*;

	localparam int WAIT_LIMIT = 20 * TICK_DIV;
	localparam int COUNT_STEPS = 105;

	logic       clk;
	logic       arst_n;
	logic       counter_en;
	alu_op_t    alu_op;
	nibble_t    alu_a;
	nibble_t    alu_b;
	word_t      sft_data;
	shamt_t     sft_shamt;
	logic       sft_shift_left;
	logic       sft_arith;
	logic [7:0] mux_in;
	logic [1:0] mux_sel;
	logic [2:0] dec_in;
	logic       dec_en;
	logic [7:0] enc_in;
	logic       enc_en;
	inc_count_t inc_count;
	dec_count_t dec_count;
	seg_t       seg0;
	seg_t       seg1;
	seg_t       seg2;
	seg_t       seg3;
	seg_t       seg4;
	seg_t       seg5;
	seg_t       seg6;
	seg_t       seg7;
	nibble_t    alu_res;
	logic       alu_zero;
	logic       alu_carry;
	logic       alu_overflow;
	word_t      sft_q;
	logic [1:0] mux_out;
	logic [7:0] dec_out;
	logic [2:0] enc_out;
	logic       enc_valid;

	logic [15:0] lfsr;
	int          checks;
	int          errors;
	int          test_checks;
	int          test_errors;
	string       test_name;

	lab_top u_lab_top (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// reporting
	// ~~~~~~~~~~~~~~~~~~~~

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("[ERROR] %s: %s expected %h actual %h", test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic end_test();
		$display("test %s: %0d checks, %0d errors", test_name, checks - test_checks,
			errors - test_errors);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// reference models
	// ~~~~~~~~~~~~~~~~~~~~

	// taps 16, 14, 13 and 11 give a maximal length sequence
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			bits = {bits[30:0], lfsr[0]};
		end
	endtask

	// one bit position per step, filling by the shift rule
	function automatic word_t expected_shift(input word_t d, input shamt_t n,
			input logic left, input logic arith);
		word_t r;
		logic  fill;
		r = d;
		fill = arith & d[31];
		for (int i = 0; i < int'(n); i++) begin
			if (left) begin
				r = {r[30:0], 1'b0};
			end else begin
				r = {fill, r[31:1]};
			end
		end
		return r;
	endfunction

	// active low patterns with the dot off
	function automatic seg_t digit_pattern(input int digit);
		case (digit)
			0:       return 8'hC0;
			1:       return 8'hF9;
			2:       return 8'hA4;
			3:       return 8'hB0;
			4:       return 8'h99;
			5:       return 8'h92;
			6:       return 8'h82;
			7:       return 8'hF8;
			8:       return 8'h80;
			9:       return 8'h90;
			default: return 8'hFF;
		endcase
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// tests
	// ~~~~~~~~~~~~~~~~~~~~

	task automatic run_stim_file();
		int          fd;
		int          ch;
		logic [7:0]  tag;
		logic [7:0]  last_tag;
		logic [31:0] v [10];
		string       what;
		fd = $fopen("verification/lab_stim.txt", "r");
		if (fd == 0) begin
			$display("the stimulus file verification/lab_stim.txt could not be opened");
			errors++;
			return;
		end
		last_tag = 8'h00;
		while ($fscanf(fd, " %c", tag) == 1) begin
			// comment lines run to the end of the line
			if (tag == "#") begin
				ch = $fgetc(fd);
				while (ch != "\n" && ch != -1) begin
					ch = $fgetc(fd);
				end
				continue;
			end
			if (tag != last_tag) begin
				if (last_tag != 8'h00) begin
					end_test();
				end
				start_test(tag == "A" ? "alu" : (tag == "S" ? "shifter" : "converter"));
				last_tag = tag;
			end
			case (tag)
				"A": begin
					void'($fscanf(fd, " %h %h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4],
						v[5], v[6]));
					alu_op = alu_op_t'(v[0]);
					alu_a = nibble_t'(v[1]);
					alu_b = nibble_t'(v[2]);
					@(negedge clk);
					what = $sformatf("op %0d a %h b %h", alu_op, alu_a, alu_b);
					check_value({what, " res"}, v[3], 32'(alu_res));
					check_value({what, " zero"}, v[4], 32'(alu_zero));
					check_value({what, " carry"}, v[5], 32'(alu_carry));
					check_value({what, " overflow"}, v[6], 32'(alu_overflow));
				end
				"S": begin
					void'($fscanf(fd, " %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4]));
					sft_data = v[0];
					sft_shamt = shamt_t'(v[1]);
					sft_shift_left = v[2][0];
					sft_arith = v[3][0];
					@(negedge clk);
					what = $sformatf("data %h shamt %0d left %0b arith %0b", sft_data,
						sft_shamt, sft_shift_left, sft_arith);
					check_value({what, " q"}, v[4], sft_q);
				end
				"C": begin
					void'($fscanf(fd, " %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
						v[3], v[4], v[5], v[6], v[7], v[8], v[9]));
					mux_in = v[0][7:0];
					mux_sel = v[1][1:0];
					dec_in = v[2][2:0];
					dec_en = v[3][0];
					enc_in = v[4][7:0];
					enc_en = v[5][0];
					@(negedge clk);
					what = $sformatf("mux %h/%0d dec %0d/%0b enc %h/%0b", mux_in, mux_sel,
						dec_in, dec_en, enc_in, enc_en);
					check_value({what, " mux_out"}, v[6], 32'(mux_out));
					check_value({what, " dec_out"}, v[7], 32'(dec_out));
					check_value({what, " enc_out"}, v[8], 32'(enc_out));
					check_value({what, " enc_valid"}, v[9], 32'(enc_valid));
				end
				default: begin
					$display("the stimulus file holds a line with an unknown tag");
					errors++;
				end
			endcase
		end
		if (last_tag != 8'h00) begin
			end_test();
		end
		$fclose(fd);
	endtask

	task automatic run_random_shifts();
		logic [31:0] r;
		string       what;
		repeat (16) begin
			take_bits(32, r);
			sft_data = r;
			take_bits(5, r);
			sft_shamt = shamt_t'(r);
			take_bits(1, r);
			sft_shift_left = r[0];
			take_bits(1, r);
			sft_arith = r[0];
			@(negedge clk);
			what = $sformatf("data %h shamt %0d left %0b arith %0b", sft_data, sft_shamt,
				sft_shift_left, sft_arith);
			check_value({what, " q"},
				expected_shift(sft_data, sft_shamt, sft_shift_left, sft_arith), sft_q);
		end
	endtask

	task automatic wait_count_change(input inc_count_t inc0, input dec_count_t dec0,
			output logic timed_out);
		int cycles;
		cycles = 0;
		while (inc_count == inc0 && dec_count == dec0 && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		timed_out = (inc_count == inc0 && dec_count == dec0);
		if (timed_out) begin
			$display("timeout: the counts did not change while counting was enabled");
			errors++;
		end
	endtask

	task automatic check_display(input int inc_exp, input int dec_exp);
		check_value("seg0", 32'(digit_pattern(inc_exp % 10)), 32'(seg0));
		check_value("seg1", 32'(digit_pattern(inc_exp / 10)), 32'(seg1));
		check_value("seg2", 32'(digit_pattern(dec_exp)), 32'(seg2));
		check_value("seg3 to seg7 all ones", 32'd1, 32'(&{seg3, seg4, seg5, seg6, seg7}));
	endtask

	task automatic run_count_test();
		int   prev_inc;
		int   prev_dec;
		int   exp_inc;
		int   exp_dec;
		logic timed_out;
		counter_en = 1'b1;
		// both counts start from their reset value
		prev_inc = 0;
		prev_dec = 0;
		for (int k = 0; k < COUNT_STEPS; k++) begin
			wait_count_change(inc_count_t'(prev_inc), dec_count_t'(prev_dec), timed_out);
			if (timed_out) begin
				return;
			end
			exp_inc = (prev_inc + 1) % (INC_MAX + 1);
			exp_dec = (prev_dec + 7) % 8;
			check_value("inc_count step", 32'(exp_inc), 32'(inc_count));
			check_value("dec_count step", 32'(exp_dec), 32'(dec_count));
			prev_inc = exp_inc;
			prev_dec = exp_dec;
			// segments load one cycle after the counts
			@(negedge clk);
			check_display(exp_inc, exp_dec);
		end
	endtask

	task automatic run_hold_test();
		inc_count_t hold_inc;
		dec_count_t hold_dec;
		counter_en = 1'b0;
		hold_inc = inc_count;
		hold_dec = dec_count;
		repeat (3 * TICK_DIV) begin
			@(negedge clk);
			check_value("inc_count held", 32'(hold_inc), 32'(inc_count));
			check_value("dec_count held", 32'(hold_dec), 32'(dec_count));
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// main sequence
	// ~~~~~~~~~~~~~~~~~~~~

	initial begin
		lfsr = 16'd99;
		checks = 0;
		errors = 0;
		arst_n = 1'b0;
		counter_en = 1'b0;
		alu_op = OP_ADD;
		alu_a = '0;
		alu_b = '0;
		sft_data = '0;
		sft_shamt = '0;
		sft_shift_left = 1'b0;
		sft_arith = 1'b0;
		mux_in = '0;
		mux_sel = '0;
		dec_in = '0;
		dec_en = 1'b0;
		enc_in = '0;
		enc_en = 1'b0;
		repeat (5) begin
			@(posedge clk);
		end
		@(negedge clk);
		arst_n = 1'b1;

		run_stim_file();
		start_test("shifter_random");
		run_random_shifts();
		end_test();
		start_test("count_and_display");
		run_count_test();
		end_test();
		start_test("hold");
		run_hold_test();
		end_test();

		errors += u_lab_top.u_tick_counters.u_lab_checker.fail_count;
		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire
